// File: source/dma_pkg.sv
// Shared definitions for the DMA target tile.
// Flit layout, header field positions, packet codes, buffer sizes and
// AHB encodings. Import with dma_pkg::* in the module header.

package dma_pkg;

  //////////////////////////////////////////////////
  // Words and flits
  //////////////////////////////////////////////////

  // One bus and payload word
  typedef logic [31:0] word_t;

  // NoC flit: type bits on top of a content word
  typedef struct packed {
    logic [1:0] ftype;
    word_t      content;
  } flit_t;

  // Flit type codes
  localparam logic [1:0] FLIT_PAYLOAD = 2'b00;
  localparam logic [1:0] FLIT_HEADER  = 2'b01;
  localparam logic [1:0] FLIT_LAST    = 2'b10;
  localparam logic [1:0] FLIT_SINGLE  = 2'b11;

  //////////////////////////////////////////////////
  // Header fields within the content word
  //////////////////////////////////////////////////

  localparam int DEST_MSB   = 31;
  localparam int DEST_LSB   = 27;
  localparam int CLASS_MSB  = 26;
  localparam int CLASS_LSB  = 24;
  localparam int SOURCE_MSB = 23;
  localparam int SOURCE_LSB = 19;
  localparam int TYPE_MSB   = 18;
  localparam int TYPE_LSB   = 17;
  localparam int ID_MSB     = 16;
  localparam int ID_LSB     = 13;
  // Request-last in requests, response-last in responses
  localparam int LAST_BIT   = 12;
  localparam int SIZE_MSB   = 11;
  localparam int SIZE_LSB   = 0;

  typedef logic [4:0]  tile_t;
  typedef logic [3:0]  pkt_id_t;
  typedef logic [11:0] size_t;

  // Packet type codes
  localparam logic [1:0] PKT_L2R_REQ  = 2'd0;
  localparam logic [1:0] PKT_R2L_REQ  = 2'd1;
  localparam logic [1:0] PKT_L2R_RESP = 2'd2;
  localparam logic [1:0] PKT_R2L_RESP = 2'd3;

  localparam logic [2:0] PKT_CLASS_DMA = 3'd2;
  localparam tile_t      TILE_ID       = 5'd3;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////

  // Input buffer holds one whole packet
  localparam int NOC_PACKET_SIZE = 16;
  // Header and address flits leave the rest for data
  localparam int READ_MAX_WORDS  = NOC_PACKET_SIZE - 2;
  localparam int READ_FIFO_DEPTH = 3;
  localparam int WORD_BYTES      = 4;

  // AHB-Lite encodings
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;
  localparam logic [2:0] HBURST_INCR   = 3'b001;

  // Request controller states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_L2R_ADDR,
    ST_L2R_DATA,
    ST_R2L_LADDR,
    ST_R2L_RADDR,
    ST_R2L_DATA,
    ST_RESP_WAIT,
    ST_DROP
  } req_state_t;

endpackage

// File: source/flit_fifo.sv
// Registered valid/ready FIFO for any payload type.
// Output comes straight from storage, so a push shows one cycle later
// and no path runs from input to output.

`timescale 1ns/1ps

module flit_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 2
) (
  input  logic     clk,
  input  logic     rst,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t           mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               push;
  logic               pop;

  assign in_ready  = (count != CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  // Storage, no reset needed
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Fill level only moves on a lone push or pop
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: source/dma_request_ctrl.sv
// Request controller of the DMA target.
// Parses request packets from the input buffer, starts bus bursts,
// gates each beat and hands finished requests to the response builder.

`timescale 1ns/1ps

module dma_request_ctrl
  import dma_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  flit_t   buf_flit,
  input  logic    buf_valid,
  output logic    buf_ready,
  output logic    burst_start,
  output word_t   burst_addr,
  output logic    burst_write,
  output logic    beat_enable,
  input  logic    beat_done,
  input  logic    rd_fifo_ready,
  output logic    resp_start,
  output logic    resp_is_read,
  output tile_t   resp_tile,
  output pkt_id_t resp_id,
  output size_t   resp_size,
  output word_t   resp_addr,
  input  logic    resp_done
);

  req_state_t state;
  req_state_t nxt_state;

  // Latched request fields
  tile_t      tile_q;
  pkt_id_t    id_q;
  size_t      size_q;
  logic       req_last;
  word_t      laddr_q;
  size_t      beat_cnt;

  logic [1:0] hdr_type;
  size_t      hdr_size;
  logic       buf_last;
  logic       hdr_take;

  assign hdr_type = buf_flit.content[TYPE_MSB:TYPE_LSB];
  assign hdr_size = buf_flit.content[SIZE_MSB:SIZE_LSB];
  // Last flit of a packet, either ending a train or standing alone
  assign buf_last = (buf_flit.ftype == FLIT_LAST) || (buf_flit.ftype == FLIT_SINGLE);
  assign hdr_take = (state == ST_IDLE) && buf_valid;

  // L2R bursts start straight from the address flit
  assign burst_write  = (state == ST_L2R_ADDR);
  assign burst_addr   = burst_write ? buf_flit.content : laddr_q;
  // Remote address flit goes along with the R2L response start
  assign resp_is_read = (state == ST_R2L_RADDR);
  assign resp_addr    = buf_flit.content;
  assign resp_tile    = tile_q;
  assign resp_id      = id_q;
  assign resp_size    = size_q;

  //////////////////////////////////////////////////
  // FSM next state and strobes
  //////////////////////////////////////////////////

  always_comb begin
    nxt_state   = state;
    buf_ready   = 1'b0;
    burst_start = 1'b0;
    beat_enable = 1'b0;
    resp_start  = 1'b0;
    case (state)
      ST_IDLE: begin
        buf_ready = buf_valid;
        if (buf_valid) begin
          if (hdr_type == PKT_L2R_REQ) begin
            nxt_state = ST_L2R_ADDR;
          end else if (hdr_type == PKT_R2L_REQ) begin
            nxt_state = ST_R2L_LADDR;
          end else if (!buf_last) begin
            // Unknown kind, skip the rest of the packet
            nxt_state = ST_DROP;
          end
        end
      end
      ST_L2R_ADDR: begin
        buf_ready = buf_valid;
        if (buf_valid) begin
          if (!buf_last) begin
            burst_start = 1'b1;
            nxt_state   = ST_L2R_DATA;
          end else if (req_last) begin
            // Empty write, only acknowledge
            resp_start = 1'b1;
            nxt_state  = ST_RESP_WAIT;
          end else begin
            nxt_state = ST_IDLE;
          end
        end
      end
      ST_L2R_DATA: begin
        // One payload flit per write beat
        beat_enable = buf_valid;
        buf_ready   = beat_done;
        if (beat_done && buf_last) begin
          resp_start = req_last;
          nxt_state  = req_last ? ST_RESP_WAIT : ST_IDLE;
        end
      end
      ST_R2L_LADDR: begin
        buf_ready = buf_valid;
        if (buf_valid) begin
          nxt_state = ST_R2L_RADDR;
        end
      end
      ST_R2L_RADDR: begin
        buf_ready = buf_valid;
        if (buf_valid) begin
          burst_start = 1'b1;
          resp_start  = 1'b1;
          nxt_state   = ST_R2L_DATA;
        end
      end
      ST_R2L_DATA: begin
        // Read while the data buffer has room and words remain
        beat_enable = rd_fifo_ready && (beat_cnt != size_q);
        if (resp_done) begin
          nxt_state = ST_IDLE;
        end
      end
      ST_RESP_WAIT: begin
        if (resp_done) begin
          nxt_state = ST_IDLE;
        end
      end
      ST_DROP: begin
        buf_ready = buf_valid;
        if (buf_valid && buf_last) begin
          nxt_state = ST_IDLE;
        end
      end
      default: nxt_state = ST_IDLE;
    endcase
  end

  //////////////////////////////////////////////////
  // State and counters
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_IDLE;
      req_last <= 1'b0;
      beat_cnt <= '0;
    end else begin
      state <= nxt_state;
      if (hdr_take) begin
        req_last <= buf_flit.content[LAST_BIT];
      end
      if (burst_start) begin
        beat_cnt <= '0;
      end else if (beat_done) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  // Header fields and local read address
  always_ff @(posedge clk) begin
    if (hdr_take) begin
      tile_q <= buf_flit.content[SOURCE_MSB:SOURCE_LSB];
      id_q   <= buf_flit.content[ID_MSB:ID_LSB];
      // Reads longer than one response packet are cut short
      size_q <= (hdr_size > size_t'(READ_MAX_WORDS)) ? size_t'(READ_MAX_WORDS) : hdr_size;
    end
    if ((state == ST_R2L_LADDR) && buf_valid) begin
      laddr_q <= buf_flit.content;
    end
  end

endmodule

// File: source/ahb_burst_master.sv
// AHB-Lite master for one incrementing burst at a time.
// Latches start address and direction, then runs a beat in every cycle
// where beat_enable and hready are both high.

`timescale 1ns/1ps

module ahb_burst_master
  import dma_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       burst_start,
  input  word_t      burst_addr,
  input  logic       burst_write,
  input  logic       beat_enable,
  output logic       beat_done,
  output logic       hsel,
  output word_t      haddr,
  output logic       hwrite,
  output logic [1:0] htrans,
  output logic [2:0] hburst,
  input  logic       hready
);

  word_t addr_q;
  logic  write_q;
  // Next beat is the first of its burst
  logic  first_q;

  // Select follows the enable in the same cycle
  assign hsel      = beat_enable;
  assign beat_done = hsel & hready;
  assign haddr     = addr_q;
  assign hwrite    = write_q;
  assign hburst    = HBURST_INCR;

  // Idle between beats, NONSEQ opens the burst, SEQ continues it
  always_comb begin
    if (!beat_enable) begin
      htrans = HTRANS_IDLE;
    end else if (first_q) begin
      htrans = HTRANS_NONSEQ;
    end else begin
      htrans = HTRANS_SEQ;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      write_q <= 1'b0;
      first_q <= 1'b0;
    end else if (burst_start) begin
      write_q <= burst_write;
      first_q <= 1'b1;
    end else if (beat_done) begin
      first_q <= 1'b0;
    end
  end

  // Running word address
  always_ff @(posedge clk) begin
    if (burst_start) begin
      addr_q <= burst_addr;
    end else if (beat_done) begin
      addr_q <= addr_q + word_t'(WORD_BYTES);
    end
  end

endmodule

// File: source/dma_response_gen.sv
// Response builder on the NoC output.
// L2R gets a single acknowledge flit. R2L gets header, address and the
// read words from the data buffer. Flits hold while noc_out_ready is low.

`timescale 1ns/1ps

module dma_response_gen
  import dma_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    resp_start,
  input  logic    resp_is_read,
  input  tile_t   resp_tile,
  input  pkt_id_t resp_id,
  input  size_t   resp_size,
  input  word_t   resp_addr,
  input  word_t   rd_data,
  input  logic    rd_valid,
  output logic    rd_pop,
  output flit_t   noc_out_flit,
  output logic    noc_out_valid,
  input  logic    noc_out_ready,
  output logic    resp_done
);

  typedef enum logic [2:0] {
    PH_IDLE,
    PH_SINGLE,
    PH_HDR,
    PH_ADDR,
    PH_DATA
  } phase_t;

  phase_t  phase;
  tile_t   tile_q;
  pkt_id_t id_q;
  size_t   size_q;
  word_t   addr_q;
  // Data flits already sent
  size_t   cnt;
  logic    accept;
  logic    last_data;
  logic    no_data;

  assign accept    = noc_out_valid & noc_out_ready;
  assign last_data = (cnt == size_q - 1'b1);
  assign no_data   = (size_q == '0);
  assign rd_pop    = (phase == PH_DATA) && accept;
  assign resp_done = accept && ((phase == PH_SINGLE) || ((phase == PH_DATA) && last_data) ||
                                ((phase == PH_ADDR) && no_data));

  //////////////////////////////////////////////////
  // Flit assembly
  //////////////////////////////////////////////////

  always_comb begin
    noc_out_flit  = '0;
    noc_out_valid = 1'b0;
    case (phase)
      PH_SINGLE: begin
        noc_out_valid                                = 1'b1;
        noc_out_flit.ftype                           = FLIT_SINGLE;
        noc_out_flit.content[DEST_MSB:DEST_LSB]      = tile_q;
        noc_out_flit.content[CLASS_MSB:CLASS_LSB]    = PKT_CLASS_DMA;
        noc_out_flit.content[ID_MSB:ID_LSB]          = id_q;
        noc_out_flit.content[TYPE_MSB:TYPE_LSB]      = PKT_L2R_RESP;
      end
      PH_HDR: begin
        noc_out_valid                                = 1'b1;
        noc_out_flit.ftype                           = FLIT_HEADER;
        noc_out_flit.content[DEST_MSB:DEST_LSB]      = tile_q;
        noc_out_flit.content[CLASS_MSB:CLASS_LSB]    = PKT_CLASS_DMA;
        noc_out_flit.content[SOURCE_MSB:SOURCE_LSB]  = TILE_ID;
        noc_out_flit.content[TYPE_MSB:TYPE_LSB]      = PKT_R2L_RESP;
        noc_out_flit.content[ID_MSB:ID_LSB]          = id_q;
        // Always a single response packet
        noc_out_flit.content[LAST_BIT]               = 1'b1;
        noc_out_flit.content[SIZE_MSB:SIZE_LSB]      = size_q;
      end
      PH_ADDR: begin
        noc_out_valid        = 1'b1;
        noc_out_flit.ftype   = no_data ? FLIT_LAST : FLIT_PAYLOAD;
        noc_out_flit.content = addr_q;
      end
      PH_DATA: begin
        // Wait on the read buffer, head word holds until popped
        noc_out_valid        = rd_valid;
        noc_out_flit.ftype   = last_data ? FLIT_LAST : FLIT_PAYLOAD;
        noc_out_flit.content = rd_data;
      end
      default: noc_out_valid = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // Phase sequencing
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      phase <= PH_IDLE;
      cnt   <= '0;
    end else begin
      case (phase)
        PH_IDLE: begin
          cnt <= '0;
          if (resp_start) begin
            phase <= resp_is_read ? PH_HDR : PH_SINGLE;
          end
        end
        PH_SINGLE: if (accept) phase <= PH_IDLE;
        PH_HDR:    if (accept) phase <= PH_ADDR;
        PH_ADDR: begin
          if (accept) begin
            phase <= no_data ? PH_IDLE : PH_DATA;
          end
        end
        PH_DATA: begin
          if (accept) begin
            cnt <= cnt + 1'b1;
            if (last_data) begin
              phase <= PH_IDLE;
            end
          end
        end
        default: phase <= PH_IDLE;
      endcase
    end
  end

  // Request fields taken with the start pulse
  always_ff @(posedge clk) begin
    if (resp_start && (phase == PH_IDLE)) begin
      tile_q <= resp_tile;
      id_q   <= resp_id;
      size_q <= resp_size;
      addr_q <= resp_addr;
    end
  end

endmodule

// File: source/dma_target_ahb.sv
// DMA target tile top level.
// NoC requests go through the packet buffer into the request controller,
// which drives the AHB-Lite master. Read words pass a small buffer into
// the response builder on the NoC output.

`timescale 1ns/1ps

module dma_target_ahb
  import dma_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  // NoC side
  input  flit_t      noc_in_flit,
  input  logic       noc_in_valid,
  output logic       noc_in_ready,
  output flit_t      noc_out_flit,
  output logic       noc_out_valid,
  input  logic       noc_out_ready,
  // AHB-Lite master
  output logic       hsel,
  output word_t      haddr,
  output word_t      hwdata,
  output logic       hwrite,
  output logic [1:0] htrans,
  output logic [2:0] hburst,
  input  word_t      hrdata,
  input  logic       hready
);

  // Packet buffer to controller
  flit_t   buf_flit;
  logic    buf_valid;
  logic    buf_ready;

  // Controller to bus master
  logic    burst_start;
  word_t   burst_addr;
  logic    burst_write;
  logic    beat_enable;
  logic    beat_done;

  // Read data path
  logic    rd_push;
  logic    rd_fifo_ready;
  word_t   rd_data;
  logic    rd_valid;
  logic    rd_pop;

  // Controller to response builder
  logic    resp_start;
  logic    resp_is_read;
  tile_t   resp_tile;
  pkt_id_t resp_id;
  size_t   resp_size;
  word_t   resp_addr;
  logic    resp_done;

  // Write beats carry the head payload flit
  assign hwdata  = buf_flit.content;
  assign rd_push = beat_done & ~hwrite;

  // Whole request packet fits in here
  flit_fifo #(.payload_t(flit_t), .DEPTH(NOC_PACKET_SIZE)) u_in_buf (
    .clk(clk), .rst(rst),
    .in_data(noc_in_flit), .in_valid(noc_in_valid), .in_ready(noc_in_ready),
    .out_data(buf_flit), .out_valid(buf_valid), .out_ready(buf_ready)
  );

  // Decouples bus reads from NoC back-pressure
  flit_fifo #(.payload_t(word_t), .DEPTH(READ_FIFO_DEPTH)) u_rd_buf (
    .clk(clk), .rst(rst),
    .in_data(hrdata), .in_valid(rd_push), .in_ready(rd_fifo_ready),
    .out_data(rd_data), .out_valid(rd_valid), .out_ready(rd_pop)
  );

  dma_request_ctrl u_request_ctrl (
    .clk(clk), .rst(rst),
    .buf_flit(buf_flit), .buf_valid(buf_valid), .buf_ready(buf_ready),
    .burst_start(burst_start), .burst_addr(burst_addr), .burst_write(burst_write),
    .beat_enable(beat_enable), .beat_done(beat_done), .rd_fifo_ready(rd_fifo_ready),
    .resp_start(resp_start), .resp_is_read(resp_is_read), .resp_tile(resp_tile),
    .resp_id(resp_id), .resp_size(resp_size), .resp_addr(resp_addr),
    .resp_done(resp_done)
  );

  ahb_burst_master u_burst_master (
    .clk(clk), .rst(rst),
    .burst_start(burst_start), .burst_addr(burst_addr), .burst_write(burst_write),
    .beat_enable(beat_enable), .beat_done(beat_done),
    .hsel(hsel), .haddr(haddr), .hwrite(hwrite), .htrans(htrans), .hburst(hburst),
    .hready(hready)
  );

  dma_response_gen u_response_gen (
    .clk(clk), .rst(rst),
    .resp_start(resp_start), .resp_is_read(resp_is_read), .resp_tile(resp_tile),
    .resp_id(resp_id), .resp_size(resp_size), .resp_addr(resp_addr),
    .rd_data(rd_data), .rd_valid(rd_valid), .rd_pop(rd_pop),
    .noc_out_flit(noc_out_flit), .noc_out_valid(noc_out_valid),
    .noc_out_ready(noc_out_ready), .resp_done(resp_done)
  );

endmodule

// File: sim/ahb_mem_model.sv
// Behavioral AHB-Lite memory slave for the DMA target testbench.
// 256 words with a fill pattern, random wait states, and a log of
// every completed beat for protocol checks.

`timescale 1ns/1ps

module ahb_mem_model
  import dma_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       hsel,
  input  word_t      haddr,
  input  word_t      hwdata,
  input  logic       hwrite,
  input  logic [1:0] htrans,
  output word_t      hrdata,
  output logic       hready
);

  localparam int WORDS   = 256;
  localparam int LOG_MAX = 512;

  word_t      mem [WORDS];
  // Completed beats, read by the testbench
  int         beat_count;
  word_t      log_addr [LOG_MAX];
  logic [1:0] log_trans [LOG_MAX];
  logic       log_write [LOG_MAX];

  // Every word differs, pattern built from the full index
  initial begin
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = 32'hc3a50000 ^ (i * 32'h00010203) ^ 32'(i);
    end
  end

  // Read data shows in the beat cycle
  assign hrdata = mem[haddr[9:2]];

  always @(posedge clk) begin
    if (rst) begin
      hready     <= 1'b1;
      beat_count <= 0;
    end else begin
      // Roughly one wait state in four
      hready <= (($urandom % 4) != 0);
      if (hsel && hready) begin
        if (hwrite) begin
          mem[haddr[9:2]] <= hwdata;
        end
        log_addr[beat_count]  <= haddr;
        log_trans[beat_count] <= htrans;
        log_write[beat_count] <= hwrite;
        beat_count            <= beat_count + 1;
      end
    end
  end

endmodule

// File: sim/tb_dma_target_ahb.sv
// Testbench for the DMA target tile.
// Applies a table of L2R, R2L and unsupported requests, then checks
// memory, the AHB beat log and the NoC response flits.

`timescale 1ns/1ps

module tb_dma_target_ahb
  import dma_pkg::*;
();

  localparam int KIND_L2R = 0;
  localparam int KIND_R2L = 1;
  localparam int KIND_BAD = 2;
  localparam int NUM_ROWS = 6;
  localparam int WAIT_MAX = 2000;
  localparam int QUIET    = 200;

  typedef struct {
    int      kind;
    tile_t   tile;
    pkt_id_t id;
    bit      last;
    word_t   addr;
    word_t   raddr;
    int      len;
    word_t   base;
  } row_t;

  logic       clk;
  logic       rst;
  flit_t      noc_in_flit;
  logic       noc_in_valid;
  logic       noc_in_ready;
  flit_t      noc_out_flit;
  logic       noc_out_valid;
  logic       noc_out_ready;
  logic       hsel;
  word_t      haddr;
  word_t      hwdata;
  logic       hwrite;
  logic [1:0] htrans;
  logic [2:0] hburst;
  word_t      hrdata;
  logic       hready;

  row_t  rows [NUM_ROWS];
  word_t exp_mem [256];
  flit_t tx_q [$];

  dma_target_ahb u_dma_target_ahb (
    .clk(clk), .rst(rst),
    .noc_in_flit(noc_in_flit), .noc_in_valid(noc_in_valid), .noc_in_ready(noc_in_ready),
    .noc_out_flit(noc_out_flit), .noc_out_valid(noc_out_valid),
    .noc_out_ready(noc_out_ready),
    .hsel(hsel), .haddr(haddr), .hwdata(hwdata), .hwrite(hwrite), .htrans(htrans),
    .hburst(hburst), .hrdata(hrdata), .hready(hready)
  );

  ahb_mem_model u_mem (
    .clk(clk), .rst(rst), .hsel(hsel), .haddr(haddr), .hwdata(hwdata),
    .hwrite(hwrite), .htrans(htrans), .hrdata(hrdata), .hready(hready)
  );

  always #20 clk = ~clk;

  // Random output back-pressure
  always @(posedge clk) begin
    noc_out_ready <= (($urandom % 3) != 0);
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic word_t fill_word(int i);
    return 32'hc3a50000 ^ (i * 32'h00010203) ^ 32'(i);
  endfunction

  function automatic word_t make_header(logic [1:0] ptype, row_t r);
    word_t w;
    w = '0;
    w[SOURCE_MSB:SOURCE_LSB] = r.tile;
    w[CLASS_MSB:CLASS_LSB]   = PKT_CLASS_DMA;
    w[TYPE_MSB:TYPE_LSB]     = ptype;
    w[ID_MSB:ID_LSB]         = r.id;
    w[LAST_BIT]              = r.last;
    w[SIZE_MSB:SIZE_LSB]     = size_t'(r.len);
    return w;
  endfunction

  task automatic check_value(string what, logic [33:0] got, logic [33:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic abort_run(string why);
    $display("%s at time %0t", why, $time);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // Sends the queued flits, called right after a rising edge
  task automatic send_packet();
    int t;
    foreach (tx_q[i]) begin
      noc_in_flit  <= tx_q[i];
      noc_in_valid <= 1'b1;
      t = 0;
      do begin
        @(negedge clk);
        t++;
        if (t > WAIT_MAX) abort_run("Input buffer never accepted a flit");
      end while (!noc_in_ready);
      @(posedge clk);
    end
    noc_in_valid <= 1'b0;
  endtask

  task automatic collect_flit(output flit_t f);
    int t;
    t = 0;
    do begin
      @(negedge clk);
      t++;
      if (t > WAIT_MAX) abort_run("No response flit arrived");
    end while (!(noc_out_valid && noc_out_ready));
    f = noc_out_flit;
  endtask

  task automatic expect_quiet();
    for (int c = 0; c < QUIET; c++) begin
      @(negedge clk);
      if (noc_out_valid) abort_run("Response flit appeared where none was due");
    end
  endtask

  task automatic wait_beats(int target);
    int t;
    t = 0;
    while (u_mem.beat_count < target) begin
      @(negedge clk);
      t++;
      if (t > WAIT_MAX) abort_run("Bus beats did not finish");
    end
  endtask

  // First beat NONSEQ, then SEQ, addresses rising by one word
  task automatic check_burst(int first, row_t r, logic wr);
    for (int k = 0; k < r.len; k++) begin
      check_value("beat address", 34'(u_mem.log_addr[first + k]), 34'(r.addr + 4 * k));
      check_value("beat htrans", 34'(u_mem.log_trans[first + k]),
                  34'((k == 0) ? HTRANS_NONSEQ : HTRANS_SEQ));
      check_value("beat direction", 34'(u_mem.log_write[first + k]), 34'(wr));
    end
  endtask

  // Every selected cycle is an incrementing burst
  always @(negedge clk) begin
    if (!rst && hsel) begin
      check_value("hburst", 34'(hburst), 34'(HBURST_INCR));
    end
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    flit_t f;
    int    first;
    word_t w;
    void'($urandom(32'hb65b));
    rows[0] = '{KIND_L2R, 5'd5, 4'd1, 1'b1, 32'h40,  32'h0,        4,  32'h1000_0000};
    rows[1] = '{KIND_L2R, 5'd6, 4'd2, 1'b0, 32'h80,  32'h0,        3,  32'h2000_0000};
    rows[2] = '{KIND_R2L, 5'd7, 4'd3, 1'b1, 32'h40,  32'habcd0000, 4,  32'h0};
    rows[3] = '{KIND_BAD, 5'd1, 4'd4, 1'b1, 32'h0,   32'h0,        2,  32'h0};
    rows[4] = '{KIND_R2L, 5'd2, 4'd5, 1'b1, 32'h100, 32'h12340040, 14, 32'h0};
    rows[5] = '{KIND_L2R, 5'd9, 4'd6, 1'b1, 32'h200, 32'h0,        8,  32'h3000_0000};
    for (int i = 0; i < 256; i++) exp_mem[i] = fill_word(i);
    clk           = 1'b0;
    rst           = 1'b1;
    noc_in_flit   = '0;
    noc_in_valid  = 1'b0;
    noc_out_ready = 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    // Quiet outputs straight after reset
    @(negedge clk);
    check_value("idle noc_out_valid", 34'(noc_out_valid), 34'(0));
    check_value("idle noc_in_ready", 34'(noc_in_ready), 34'(1));
    check_value("idle hsel", 34'(hsel), 34'(0));
    check_value("idle htrans", 34'(htrans), 34'(HTRANS_IDLE));
    @(posedge clk);

    foreach (rows[r]) begin
      first = u_mem.beat_count;
      tx_q.delete();
      case (rows[r].kind)
        KIND_L2R: begin
          tx_q.push_back({FLIT_HEADER, make_header(PKT_L2R_REQ, rows[r])});
          tx_q.push_back({FLIT_PAYLOAD, rows[r].addr});
          for (int k = 0; k < rows[r].len; k++) begin
            w = rows[r].base + word_t'(k);
            tx_q.push_back({(k == rows[r].len - 1) ? FLIT_LAST : FLIT_PAYLOAD, w});
            exp_mem[rows[r].addr[9:2] + k] = w;
          end
          send_packet();
          if (rows[r].last) begin
            collect_flit(f);
            check_value("L2R flit type", 34'(f.ftype), 34'(FLIT_SINGLE));
            check_value("L2R dest", 34'(f.content[DEST_MSB:DEST_LSB]), 34'(rows[r].tile));
            check_value("L2R class", 34'(f.content[CLASS_MSB:CLASS_LSB]), 34'(PKT_CLASS_DMA));
            check_value("L2R id", 34'(f.content[ID_MSB:ID_LSB]), 34'(rows[r].id));
            check_value("L2R type", 34'(f.content[TYPE_MSB:TYPE_LSB]), 34'(PKT_L2R_RESP));
          end else begin
            wait_beats(first + rows[r].len);
          end
          expect_quiet();
          check_value("write beat count", 34'(u_mem.beat_count), 34'(first + rows[r].len));
          for (int k = 0; k < rows[r].len; k++) begin
            check_value("memory word", 34'(u_mem.mem[rows[r].addr[9:2] + k]),
                        34'(exp_mem[rows[r].addr[9:2] + k]));
          end
          check_burst(first, rows[r], 1'b1);
        end
        KIND_R2L: begin
          tx_q.push_back({FLIT_HEADER, make_header(PKT_R2L_REQ, rows[r])});
          tx_q.push_back({FLIT_PAYLOAD, rows[r].addr});
          tx_q.push_back({FLIT_LAST, rows[r].raddr});
          send_packet();
          collect_flit(f);
          check_value("R2L header type", 34'(f.ftype), 34'(FLIT_HEADER));
          check_value("R2L dest", 34'(f.content[DEST_MSB:DEST_LSB]), 34'(rows[r].tile));
          check_value("R2L class", 34'(f.content[CLASS_MSB:CLASS_LSB]), 34'(PKT_CLASS_DMA));
          check_value("R2L packet type", 34'(f.content[TYPE_MSB:TYPE_LSB]),
                      34'(PKT_R2L_RESP));
          check_value("R2L id", 34'(f.content[ID_MSB:ID_LSB]), 34'(rows[r].id));
          check_value("R2L source", 34'(f.content[SOURCE_MSB:SOURCE_LSB]), 34'(TILE_ID));
          check_value("R2L size", 34'(f.content[SIZE_MSB:SIZE_LSB]), 34'(rows[r].len));
          check_value("R2L last bit", 34'(f.content[LAST_BIT]), 34'(1));
          collect_flit(f);
          check_value("R2L address flit", f, {FLIT_PAYLOAD, rows[r].raddr});
          for (int k = 0; k < rows[r].len; k++) begin
            collect_flit(f);
            check_value("R2L data flit", f,
                        {(k == rows[r].len - 1) ? FLIT_LAST : FLIT_PAYLOAD,
                         exp_mem[rows[r].addr[9:2] + k]});
          end
          expect_quiet();
          check_value("read beat count", 34'(u_mem.beat_count), 34'(first + rows[r].len));
          check_burst(first, rows[r], 1'b0);
        end
        default: begin
          // Response type arriving as a request is skipped whole
          tx_q.push_back({FLIT_HEADER, make_header(PKT_L2R_RESP, rows[r])});
          tx_q.push_back({FLIT_PAYLOAD, 32'h0000_0010});
          tx_q.push_back({FLIT_LAST, 32'hdead_beef});
          send_packet();
          expect_quiet();
          check_value("dropped packet beats", 34'(u_mem.beat_count), 34'(first));
        end
      endcase
      @(posedge clk);
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: project.f
source/dma_pkg.sv
source/flit_fifo.sv
source/dma_request_ctrl.sv
source/ahb_burst_master.sv
source/dma_response_gen.sv
source/dma_target_ahb.sv
sim/ahb_mem_model.sv
sim/tb_dma_target_ahb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_dma_target_ahb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
